// File: rtl/tag_mem_pkg.sv
// shared widths, bank codes, select action table and bus structs for the tag memory interface
package tag_mem_pkg;

    localparam int WORD_W      = 16;
    localparam int ADDR_W      = 6;
    localparam int BANK_DEPTH  = 64;
    localparam int BIT_CNT_W   = $clog2(WORD_W);

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [ADDR_W-1:0] addr_t;

    typedef enum logic [1:0] {
        BANK_NONE    = 2'd0,
        BANK_EPC     = 2'd1,
        BANK_SENSOR1 = 2'd2,
        BANK_SENSOR2 = 2'd3
    } bank_t;

    typedef enum logic [1:0] {
        CMD_SELECT,
        CMD_EPC_WRITE,
        CMD_EPC_READ,
        CMD_SENSOR_READ
    } cmd_kind_t;

    typedef struct packed {
        cmd_kind_t   kind;
        bank_t       membank;  // sensor bank for a sensor read
        logic [2:0]  target;
        logic [2:0]  action;
        addr_t       pointer;
        logic [6:0]  count;
        word_t       data;     // select mask or write word
    } tag_cmd_t;

    typedef struct packed {
        bank_t       sensor;
        logic [7:0]  time_stamp;
        logic [7:0]  adc;
    } sensor_sample_t;

    typedef struct packed {
        logic        write;
        bank_t       bank;
        addr_t       addr;
        word_t       wdata;
    } mem_access_t;

    typedef struct packed {
        bank_t       bank;
        addr_t       addr;
        logic        pc_b;
        logic        we;
        logic        se;
        word_t       wdata;
    } mem_ctrl_t;

    typedef struct packed {
        logic [1:0]  session;
        logic        inven_flag;
        logic        sl_flag;
    } tag_flags_t;

    localparam addr_t      CODE_WORD_ADDR = 6'd2;
    localparam int         SAMPLE_CREDITS = 1;
    localparam int         TX_CREDIT_MAX  = 8;
    localparam int         TX_CREDIT_W    = $clog2(TX_CREDIT_MAX + 1);
    localparam logic [2:0] TARGET_SL      = 3'd4;

    // what a select action does to the addressed flag
    typedef enum logic [1:0] {FLAG_KEEP, FLAG_SET, FLAG_CLEAR, FLAG_TOGGLE} flag_op_t;

    localparam flag_op_t ACT_ON_MATCH [8] = '{FLAG_SET, FLAG_SET, FLAG_KEEP, FLAG_TOGGLE,
                                             FLAG_CLEAR, FLAG_CLEAR, FLAG_KEEP, FLAG_KEEP};
    localparam flag_op_t ACT_ON_MISS  [8] = '{FLAG_CLEAR, FLAG_KEEP, FLAG_CLEAR, FLAG_KEEP,
                                             FLAG_SET, FLAG_KEEP, FLAG_SET, FLAG_TOGGLE};

endpackage

// File: rtl/select_flags.sv
// session and tag flag state, updated by select commands against the snooped EPC code word
`timescale 1ns/1ps

module select_flags import tag_mem_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        sel_valid,
    input  tag_cmd_t    cmd,
    input  logic        epc_write_valid,
    input  mem_access_t epc_write,
    output tag_flags_t  flags
);

    word_t    code_word;
    logic     match;
    logic     applies;
    flag_op_t op;

    function automatic logic apply_op(input flag_op_t fop, input logic cur);
        case (fop)
            FLAG_SET:    apply_op = 1'b1;
            FLAG_CLEAR:  apply_op = 1'b0;
            FLAG_TOGGLE: apply_op = !cur;
            default:     apply_op = cur;
        endcase
    endfunction

    assign match   = (cmd.data == code_word);
    assign applies = sel_valid && cmd.membank == BANK_EPC && cmd.target <= TARGET_SL;
    assign op      = match ? ACT_ON_MATCH[cmd.action] : ACT_ON_MISS[cmd.action];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            code_word <= '0;
        end else if (epc_write_valid && epc_write.bank == BANK_EPC &&
                     epc_write.addr == CODE_WORD_ADDR) begin
            code_word <= epc_write.wdata;  // snoop
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            flags.session    <= 2'd0;
            flags.inven_flag <= 1'b1;
            flags.sl_flag    <= 1'b1;
        end else if (applies) begin
            if (cmd.target == TARGET_SL) begin
                flags.sl_flag <= apply_op(op, flags.sl_flag);
            end else begin
                flags.inven_flag <= apply_op(op, flags.inven_flag);
                flags.session    <= cmd.target[1:0];  // targets 0..3 pick the session
            end
        end
    end

    a_session_only_on_select: assert property (
        @(posedge clk) disable iff (reset)
        !$past(sel_valid) |-> $stable(flags.session)
    );

endmodule

// File: rtl/access_planner.sv
// command intake, sample slot, sensor fill pointers and ordering of memory accesses for the tag
`timescale 1ns/1ps

module access_planner import tag_mem_pkg::*; (
    input  logic           clk,
    input  logic           reset,
    input  logic           cmd_valid,
    input  tag_cmd_t       cmd,
    output logic           cmd_ready,
    input  logic           sample_valid,
    input  sensor_sample_t sample,
    output logic           sample_credit,
    output logic           access_valid,
    output mem_access_t    access,
    input  logic           access_done,
    input  word_t          rdata,
    input  logic           word_free,
    output logic           word_valid,
    output word_t          word,
    output logic           word_last,
    output logic           sel_valid,
    output logic           epc_write_valid,
    output mem_access_t    epc_write
);

    typedef enum logic [1:0] {M_IDLE, M_WRITE, M_READ} mode_t;

    mode_t           mode;
    tag_cmd_t        cur_cmd;
    sensor_sample_t  slot;
    logic            slot_full;
    logic            slot_ok;
    logic [ADDR_W:0] fill1;
    logic [ADDR_W:0] fill2;
    logic [ADDR_W:0] slot_fill;
    logic [ADDR_W:0] rd_fill;
    logic            cmd_fire;
    logic            busy;
    logic            own_sample;  // outstanding access is the sample write
    addr_t           rd_addr;
    logic [6:0]      rd_left;
    logic            rd_down;
    logic            buf_empty;

    assign cmd_ready       = (mode == M_IDLE);
    assign cmd_fire        = cmd_valid && cmd_ready;
    assign sel_valid       = cmd_fire && cmd.kind == CMD_SELECT;
    assign slot_fill       = (slot.sensor == BANK_SENSOR2) ? fill2 : fill1;
    assign rd_fill         = (cmd.membank == BANK_SENSOR2) ? fill2 : fill1;
    assign slot_ok         = (slot.sensor == BANK_SENSOR1 || slot.sensor == BANK_SENSOR2) &&
                             slot_fill != BANK_DEPTH;
    assign buf_empty       = word_free && !word_valid;
    assign epc_write_valid = access_done && access.write;
    assign epc_write       = access;

    always_ff @(posedge clk) begin
        if (cmd_fire)
            cur_cmd <= cmd;
        if (sample_valid)
            slot <= sample;
        if (access_done && !access.write) begin
            word      <= rdata;
            word_last <= (rd_left == 7'd1);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mode          <= M_IDLE;
            slot_full     <= 1'b0;
            fill1         <= '0;
            fill2         <= '0;
            busy          <= 1'b0;
            own_sample    <= 1'b0;
            rd_addr       <= '0;
            rd_left       <= '0;
            rd_down       <= 1'b0;
            access_valid  <= 1'b0;
            access        <= '0;
            sample_credit <= 1'b0;
            word_valid    <= 1'b0;
        end else begin
            access_valid  <= 1'b0;
            sample_credit <= 1'b0;
            word_valid    <= 1'b0;
            if (sample_valid)
                slot_full <= 1'b1;
            if (cmd_fire) begin
                case (cmd.kind)
                    CMD_EPC_WRITE: mode <= M_WRITE;
                    CMD_EPC_READ: begin
                        rd_addr <= cmd.pointer;
                        rd_left <= cmd.count;
                        rd_down <= 1'b0;
                        if (cmd.count != 0)
                            mode <= M_READ;
                    end
                    CMD_SENSOR_READ: begin
                        rd_addr <= addr_t'(rd_fill - 1'b1);  // newest sample first
                        rd_left <= rd_fill;
                        rd_down <= 1'b1;
                        if (rd_fill != 0)
                            mode <= M_READ;  // empty bank stays idle
                    end
                    default: ;
                endcase
            end
            if (access_done) begin
                busy <= 1'b0;
                if (own_sample) begin
                    slot_full     <= 1'b0;
                    sample_credit <= 1'b1;
                    if (slot.sensor == BANK_SENSOR2)
                        fill2 <= fill2 + 1'b1;
                    else
                        fill1 <= fill1 + 1'b1;
                end else if (mode == M_WRITE) begin
                    mode <= M_IDLE;
                end else begin
                    word_valid <= 1'b1;
                    rd_left    <= rd_left - 1'b1;
                    rd_addr    <= rd_down ? rd_addr - 1'b1 : rd_addr + 1'b1;
                end
            end else if (!busy) begin
                if (slot_full && !slot_ok) begin
                    slot_full     <= 1'b0;  // full bank, drop it
                    sample_credit <= 1'b1;
                end else if (slot_full) begin
                    access_valid <= 1'b1;
                    busy         <= 1'b1;
                    own_sample   <= 1'b1;
                    access <= '{write: 1'b1, bank: slot.sensor, addr: addr_t'(slot_fill),
                                wdata: {slot.time_stamp, slot.adc}};
                end else if (mode == M_WRITE) begin
                    access_valid <= 1'b1;
                    busy         <= 1'b1;
                    own_sample   <= 1'b0;
                    access <= '{write: 1'b1, bank: BANK_EPC, addr: cur_cmd.pointer,
                                wdata: cur_cmd.data};
                end else if (mode == M_READ && rd_left != 0 && buf_empty) begin
                    access_valid <= 1'b1;
                    busy         <= 1'b1;
                    own_sample   <= 1'b0;
                    access <= '{write: 1'b0, bank: rd_down ? cur_cmd.membank : BANK_EPC,
                                addr: rd_addr, wdata: '0};
                end else if (mode == M_READ && rd_left == 0 && buf_empty) begin
                    mode <= M_IDLE;  // last word fully shifted out
                end
            end
        end
    end

    a_sample_needs_credit: assert property (
        @(posedge clk) disable iff (reset)
        sample_valid |-> !slot_full
    );

endmodule

// File: rtl/mem_sequencer.sv
// strobe sequencing for one read or write access of the word-addressed memory macro
`timescale 1ns/1ps

module mem_sequencer import tag_mem_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        access_valid,
    input  mem_access_t access,
    output logic        access_done,
    output word_t       rdata,
    output mem_ctrl_t   mem,
    input  word_t       mem_rdata
);

    typedef enum logic [2:0] {
        PH_IDLE,
        PH_SEL,
        PH_PRE,
        PH_ADDR,
        PH_EN,
        PH_CAP,
        PH_REL
    } phase_t;

    phase_t      state;
    mem_access_t req;

    assign access_done = (state == PH_REL);

    always_ff @(posedge clk) begin
        if (state == PH_IDLE && access_valid)
            req <= access;
        if (state == PH_CAP && mem.se)
            rdata <= mem_rdata;  // sense data valid here
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= PH_IDLE;
            mem   <= '{bank: BANK_NONE, addr: '0, pc_b: 1'b1, we: 1'b0, se: 1'b0, wdata: '0};
        end else begin
            case (state)
                PH_IDLE: begin
                    if (access_valid) begin
                        state    <= PH_SEL;
                        mem.bank <= access.bank;
                    end
                end
                PH_SEL: begin
                    state    <= PH_PRE;
                    mem.pc_b <= 1'b0;
                end
                PH_PRE: begin
                    state     <= PH_ADDR;
                    mem.addr  <= req.addr;
                    mem.wdata <= req.wdata;
                end
                PH_ADDR: begin
                    state  <= PH_EN;
                    mem.we <= req.write;
                    mem.se <= !req.write;
                end
                PH_EN: begin
                    state <= PH_CAP;  // strobes held a second cycle
                end
                PH_CAP: begin
                    state    <= PH_REL;
                    mem.pc_b <= 1'b1;
                    mem.we   <= 1'b0;
                    mem.se   <= 1'b0;
                end
                PH_REL: begin
                    state    <= PH_IDLE;
                    mem.bank <= BANK_NONE;
                end
                default: begin
                    state <= PH_IDLE;
                end
            endcase
        end
    end

    a_we_se_exclusive: assert property (
        @(posedge clk) disable iff (reset)
        !(mem.we && mem.se)
    );

    a_strobes_need_precharge_low: assert property (
        @(posedge clk) disable iff (reset)
        mem.pc_b |-> !(mem.we || mem.se)
    );

endmodule

// File: rtl/word_serializer.sv
// one-word buffer shifted out lsb first, paced by bit credits from the modulator
`timescale 1ns/1ps

module word_serializer import tag_mem_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  word_valid,
    input  word_t word,
    input  logic  word_last,
    output logic  word_free,
    input  logic  tx_credit,
    output logic  tx_bit_valid,
    output logic  tx_bit,
    output logic  tx_last
);

    logic [TX_CREDIT_W-1:0] credits;
    logic [BIT_CNT_W-1:0]   bit_cnt;
    word_t                  shreg;
    logic                   last_word;
    logic                   full;
    logic                   send;
    logic                   gain;

    assign word_free = !full;
    assign send      = full && credits != 0;
    assign gain      = tx_credit && (credits != TX_CREDIT_MAX || send);  // excess lost

    always_ff @(posedge clk) begin
        if (send) begin
            shreg <= shreg >> 1;
        end else if (word_valid && !full) begin
            shreg     <= word;
            last_word <= word_last;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            credits      <= '0;
            bit_cnt      <= '0;
            full         <= 1'b0;
            tx_bit_valid <= 1'b0;
            tx_bit       <= 1'b0;
            tx_last      <= 1'b0;
        end else begin
            credits      <= credits + TX_CREDIT_W'(gain) - TX_CREDIT_W'(send);
            tx_bit_valid <= send;
            tx_last      <= send && last_word && bit_cnt == BIT_CNT_W'(WORD_W - 1);
            if (send) begin
                tx_bit  <= shreg[0];
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == BIT_CNT_W'(WORD_W - 1))
                    full <= 1'b0;
            end else if (word_valid && !full) begin
                full    <= 1'b1;
                bit_cnt <= '0;
            end
        end
    end

    a_word_only_when_free: assert property (
        @(posedge clk) disable iff (reset)
        word_valid |-> word_free
    );

endmodule

// File: rtl/tag_mem_top.sv
// top level of the tag memory interface, connecting flags, planner, sequencer and serializer
`timescale 1ns/1ps

module tag_mem_top import tag_mem_pkg::*; (
    input  logic           clk,
    input  logic           reset,
    input  logic           cmd_valid,
    input  tag_cmd_t       cmd,
    output logic           cmd_ready,
    input  logic           sample_valid,
    input  sensor_sample_t sample,
    output logic           sample_credit,
    input  logic           tx_credit,
    output logic           tx_bit_valid,
    output logic           tx_bit,
    output logic           tx_last,
    output mem_ctrl_t      mem,
    input  word_t          mem_rdata,
    output tag_flags_t     flags
);

    logic        sel_valid;
    logic        epc_write_valid;
    mem_access_t epc_write;
    logic        access_valid;
    mem_access_t access;
    logic        access_done;
    word_t       rdata;
    logic        word_free;
    logic        word_valid;
    word_t       word;
    logic        word_last;

    select_flags i_select_flags (
        .clk             (clk),
        .reset           (reset),
        .sel_valid       (sel_valid),
        .cmd             (cmd),
        .epc_write_valid (epc_write_valid),
        .epc_write       (epc_write),
        .flags           (flags)
    );

    access_planner i_access_planner (
        .clk             (clk),
        .reset           (reset),
        .cmd_valid       (cmd_valid),
        .cmd             (cmd),
        .cmd_ready       (cmd_ready),
        .sample_valid    (sample_valid),
        .sample          (sample),
        .sample_credit   (sample_credit),
        .access_valid    (access_valid),
        .access          (access),
        .access_done     (access_done),
        .rdata           (rdata),
        .word_free       (word_free),
        .word_valid      (word_valid),
        .word            (word),
        .word_last       (word_last),
        .sel_valid       (sel_valid),
        .epc_write_valid (epc_write_valid),
        .epc_write       (epc_write)
    );

    mem_sequencer i_mem_sequencer (
        .clk          (clk),
        .reset        (reset),
        .access_valid (access_valid),
        .access       (access),
        .access_done  (access_done),
        .rdata        (rdata),
        .mem          (mem),
        .mem_rdata    (mem_rdata)
    );

    word_serializer i_word_serializer (
        .clk          (clk),
        .reset        (reset),
        .word_valid   (word_valid),
        .word         (word),
        .word_last    (word_last),
        .word_free    (word_free),
        .tx_credit    (tx_credit),
        .tx_bit_valid (tx_bit_valid),
        .tx_bit       (tx_bit),
        .tx_last      (tx_last)
    );

endmodule

// File: testbench/tb_sram_model.sv
// behavioral memory macro for the testbench, three banks of 64 words driven by the tag strobes
`timescale 1ns/1ps

module tb_sram_model import tag_mem_pkg::*; (
    input  logic      clk,
    input  mem_ctrl_t mem,
    output word_t     mem_rdata
);

    word_t cells [1:3][BANK_DEPTH];

    initial begin
        for (int b = 1; b <= 3; b++) begin
            for (int a = 0; a < BANK_DEPTH; a++) begin
                cells[b][a] <= {4'h5, 2'(b), 4'h0, 6'(a)};  // bank and address in the word
            end
        end
    end

    always @(posedge clk) begin
        if (mem.we && !mem.pc_b && mem.bank != BANK_NONE)
            cells[mem.bank][mem.addr] <= mem.wdata;
    end

    always_comb begin
        mem_rdata = '0;
        if (mem.se && mem.bank != BANK_NONE)
            mem_rdata = cells[mem.bank][mem.addr];  // only while sensing
    end

endmodule

// File: testbench/tb_tag_mem.sv
// directed testbench for the tag memory interface, top of the simulation with the memory model
`timescale 1ns/1ps

module tb_tag_mem import tag_mem_pkg::*; ();

    localparam int WAIT_LIMIT  = 400;
    localparam int BIT_LIMIT   = 1000;
    localparam int HOLD_CYCLES = 100;
    localparam int NUM_SAMPLES = 10;

    logic           clk;
    logic           reset;
    logic           cmd_valid;
    tag_cmd_t       cmd;
    logic           cmd_ready;
    logic           sample_valid;
    sensor_sample_t sample;
    logic           sample_credit;
    logic           tx_credit;
    logic           tx_bit_valid;
    logic           tx_bit;
    logic           tx_last;
    mem_ctrl_t      mem;
    word_t          mem_rdata;
    tag_flags_t     flags;

    logic        credit_en;
    logic [31:0] lcg_state;
    int          value_errors;
    int          timeout_errors;
    word_t       epc_vals [5];
    word_t       rx_words [$];
    word_t       exp_words [$];
    word_t       log1 [$];
    word_t       log2 [$];
    tag_flags_t  exp_flags;

    tag_mem_top i_tag_mem_top (
        .clk           (clk),
        .reset         (reset),
        .cmd_valid     (cmd_valid),
        .cmd           (cmd),
        .cmd_ready     (cmd_ready),
        .sample_valid  (sample_valid),
        .sample        (sample),
        .sample_credit (sample_credit),
        .tx_credit     (tx_credit),
        .tx_bit_valid  (tx_bit_valid),
        .tx_bit        (tx_bit),
        .tx_last       (tx_last),
        .mem           (mem),
        .mem_rdata     (mem_rdata),
        .flags         (flags)
    );

    tb_sram_model i_sram (
        .clk       (clk),
        .mem       (mem),
        .mem_rdata (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = !clk;
    end

    // modulator grants one bit per cycle while enabled
    initial begin
        tx_credit <= 1'b0;
        forever begin
            @(posedge clk);
            tx_credit <= credit_en;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // flag update of the select action table
    function automatic logic next_flag(input logic [2:0] action, input logic match,
                                       input logic cur);
        case (action)
            3'd0:    next_flag = match;
            3'd1:    next_flag = match ? 1'b1 : cur;
            3'd2:    next_flag = match ? cur : 1'b0;
            3'd3:    next_flag = match ? !cur : cur;
            3'd4:    next_flag = !match;
            3'd5:    next_flag = match ? 1'b0 : cur;
            3'd6:    next_flag = match ? cur : 1'b1;
            default: next_flag = match ? cur : !cur;
        endcase
    endfunction

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flags(input tag_flags_t got, input tag_flags_t exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        timeout_errors++;
        $display("timed out at %0t while waiting for %s", $time, what);
    endtask

    task automatic wait_ready(input string what);
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!cmd_ready && waited < WAIT_LIMIT);
        if (!cmd_ready)
            report_timeout({"cmd_ready ", what});
    endtask

    task automatic send_cmd(input tag_cmd_t c);
        wait_ready("before a command");
        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd       <= c;
        @(posedge clk);
        cmd_valid <= 1'b0;  // taken on this edge
    endtask

    task automatic send_sample(input sensor_sample_t s);
        int waited;
        @(posedge clk);
        sample_valid <= 1'b1;
        sample       <= s;
        @(posedge clk);
        sample_valid <= 1'b0;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!sample_credit && waited < WAIT_LIMIT);
        if (!sample_credit)
            report_timeout("sample_credit");
    endtask

    // gathers tx bits lsb first into rx_words
    task automatic collect_words(input int n);
        word_t w;
        int    waited;
        rx_words.delete();
        for (int i = 0; i < n; i++) begin
            w = '0;
            for (int b = 0; b < WORD_W; b++) begin
                waited = 0;
                do begin
                    @(negedge clk);
                    waited++;
                end while (!tx_bit_valid && waited < BIT_LIMIT);
                if (!tx_bit_valid) begin
                    report_timeout($sformatf("tx bit %0d of word %0d", b, i));
                    return;
                end
                w[b] = tx_bit;
                check_bit(tx_last, i == n - 1 && b == WORD_W - 1,
                          $sformatf("tx_last at word %0d bit %0d", i, b));
            end
            rx_words.push_back(w);
        end
    endtask

    task automatic compare_read(input string what);
        if (rx_words.size() != exp_words.size()) begin
            value_errors++;
            $display("%s returned %0d words instead of %0d", what, rx_words.size(),
                     exp_words.size());
        end
        for (int i = 0; i < exp_words.size() && i < rx_words.size(); i++)
            check_word(rx_words[i], exp_words[i], $sformatf("%s word %0d", what, i));
    endtask

    task automatic test_reset();
        @(negedge clk);
        check_flags(flags, exp_flags, "flags after reset");
        check_bit(cmd_ready, 1'b1, "cmd_ready after reset");
        check_bit(tx_bit_valid, 1'b0, "tx_bit_valid after reset");
        check_bit(tx_last, 1'b0, "tx_last after reset");
        check_bit(sample_credit, 1'b0, "sample_credit after reset");
        check_bit(mem.pc_b, 1'b1, "pc_b after reset");
        check_bit(mem.we, 1'b0, "we after reset");
        check_bit(mem.se, 1'b0, "se after reset");
        check_word(word_t'(mem.bank), word_t'(BANK_NONE), "bank after reset");
    endtask

    task automatic test_epc_rw();
        tag_cmd_t c;
        for (int i = 0; i < 5; i++) begin
            epc_vals[i] = 16'hc0de ^ word_t'(i * 16'h1357);
            c         = '0;
            c.kind    = CMD_EPC_WRITE;
            c.membank = BANK_EPC;
            c.pointer = addr_t'(i);
            c.data    = epc_vals[i];
            send_cmd(c);
            wait_ready("after epc write");
        end
        c         = '0;
        c.kind    = CMD_EPC_READ;
        c.membank = BANK_EPC;
        c.pointer = 6'd1;
        c.count   = 7'd3;
        exp_words.delete();
        for (int i = 1; i <= 3; i++)
            exp_words.push_back(epc_vals[i]);
        send_cmd(c);
        collect_words(3);
        compare_read("epc read");
        wait_ready("after epc read");
    endtask

    task automatic test_select();
        tag_cmd_t c;
        logic     match;
        logic     cur;
        for (int t = 0; t <= 4; t++) begin
            for (int a = 0; a < 8; a++) begin
                for (int m = 0; m < 2; m++) begin
                    match     = (m == 1);
                    c         = '0;
                    c.kind    = CMD_SELECT;
                    c.membank = BANK_EPC;
                    c.target  = 3'(t);
                    c.action  = 3'(a);
                    c.data    = match ? epc_vals[2] : ~epc_vals[2];  // word 2 is the code word
                    if (t == 4) begin
                        cur               = exp_flags.sl_flag;
                        exp_flags.sl_flag = next_flag(3'(a), match, cur);
                    end else begin
                        cur                  = exp_flags.inven_flag;
                        exp_flags.inven_flag = next_flag(3'(a), match, cur);
                        exp_flags.session    = 2'(t);
                    end
                    send_cmd(c);
                    @(negedge clk);
                    check_flags(flags, exp_flags,
                                $sformatf("select target %0d action %0d match %0d", t, a, m));
                end
            end
        end
        c         = '0;
        c.kind    = CMD_SELECT;
        c.membank = BANK_SENSOR1;
        c.data    = epc_vals[2];
        send_cmd(c);
        @(negedge clk);
        check_flags(flags, exp_flags, "select on sensor bank");
        c.membank = BANK_EPC;
        c.target  = 3'd5;
        send_cmd(c);
        @(negedge clk);
        check_flags(flags, exp_flags, "select with target 5");
    endtask

    task automatic read_sensor(input bank_t b);
        tag_cmd_t c;
        exp_words.delete();
        if (b == BANK_SENSOR2) begin
            foreach (log2[i])
                exp_words.push_front(log2[i]);  // newest first
        end else begin
            foreach (log1[i])
                exp_words.push_front(log1[i]);
        end
        c         = '0;
        c.kind    = CMD_SENSOR_READ;
        c.membank = b;
        send_cmd(c);
        collect_words(exp_words.size());
        compare_read($sformatf("sensor bank %0d read", b));
        wait_ready("after sensor read");
    endtask

    task automatic test_sensor();
        tag_cmd_t       c;
        sensor_sample_t s;
        logic [31:0]    r;
        c         = '0;
        c.kind    = CMD_SENSOR_READ;
        c.membank = BANK_SENSOR1;
        send_cmd(c);
        @(negedge clk);
        check_bit(cmd_ready, 1'b1, "cmd_ready after read of empty sensor bank");
        for (int i = 0; i < NUM_SAMPLES; i++) begin
            r            = lcg_next();
            s.sensor     = (i % 2 == 1) ? BANK_SENSOR2 : BANK_SENSOR1;
            s.time_stamp = r[23:16];
            s.adc        = r[15:8];
            send_sample(s);
            if (s.sensor == BANK_SENSOR2)
                log2.push_back({s.time_stamp, s.adc});
            else
                log1.push_back({s.time_stamp, s.adc});
        end
        read_sensor(BANK_SENSOR1);
        read_sensor(BANK_SENSOR2);
    endtask

    // lets the stored credits drain, then watches a stalled read
    task automatic hold_check();
        int seen;
        int waited;
        seen   = 0;
        waited = 0;
        while (seen < TX_CREDIT_MAX && waited < BIT_LIMIT) begin
            @(negedge clk);
            waited++;
            if (tx_bit_valid)
                seen++;
        end
        if (seen < TX_CREDIT_MAX)
            report_timeout("bits of the stored tx credits");
        repeat (HOLD_CYCLES) begin
            @(negedge clk);
            check_bit(tx_bit_valid, 1'b0, "tx_bit_valid without credit");
            check_bit(cmd_ready, 1'b0, "cmd_ready during stalled read");
        end
        @(posedge clk);
        credit_en <= 1'b1;
    endtask

    task automatic test_backpressure();
        tag_cmd_t c;
        @(posedge clk);
        credit_en <= 1'b0;
        c         = '0;
        c.kind    = CMD_EPC_READ;
        c.membank = BANK_EPC;
        c.count   = 7'd5;
        exp_words.delete();
        foreach (epc_vals[i])
            exp_words.push_back(epc_vals[i]);
        send_cmd(c);
        fork
            collect_words(5);
            hold_check();
        join
        compare_read("stalled epc read");
        wait_ready("after stalled read");
    endtask

    initial begin
        reset          <= 1'b1;
        cmd_valid      <= 1'b0;
        cmd            <= '0;
        sample_valid   <= 1'b0;
        sample         <= '0;
        credit_en      <= 1'b0;
        lcg_state      = 32'hdc9b_466d;
        value_errors   = 0;
        timeout_errors = 0;
        exp_flags      = '{session: 2'd0, inven_flag: 1'b1, sl_flag: 1'b1};
        repeat (16) @(posedge clk);
        reset     <= 1'b0;
        credit_en <= 1'b1;
        test_reset();
        test_epc_rw();
        test_select();
        test_sensor();
        test_backpressure();
        $display("errors: %0d wrong values, %0d timeouts", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: vlog.f
rtl/tag_mem_pkg.sv
rtl/select_flags.sv
rtl/access_planner.sv
rtl/mem_sequencer.sv
rtl/word_serializer.sv
rtl/tag_mem_top.sv
testbench/tb_sram_model.sv
testbench/tb_tag_mem.sv

// File: Makefile
TOP := tb_tag_mem

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f vlog.f --top-module tag_mem_top

sim:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "^ALL CHECKS PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log
